// ==== files.f ====
design/wb_pkg.sv
design/wb_frame_ctrl.sv
design/wb_frame_stats.sv
design/wb_gain_calc.sv
design/wb_pixel_scale.sv
design/wb_delay_line.sv
design/white_balance.sv
testbench/tb_white_balance.sv

// ==== Bender.yml ====
package:
  name: white_balance

sources:
  - files:
      - design/wb_pkg.sv
      - design/wb_frame_ctrl.sv
      - design/wb_frame_stats.sv
      - design/wb_gain_calc.sv
      - design/wb_pixel_scale.sv
      - design/wb_delay_line.sv
      - design/white_balance.sv
  - target: test
    files:
      - testbench/tb_white_balance.sv

// ==== testbench/tb_white_balance.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_white_balance import wb_pkg::*; ();

    localparam int H_ACT        = 16;
    localparam int V_ACT        = 8;
    localparam int DARK_LEVEL   = 4;
    localparam int X_W          = $clog2(H_ACT);
    localparam int Y_W          = $clog2(V_ACT);
    localparam int HBLANK       = 4;
    localparam int VBLANK       = 200;
    localparam int VSYNC_LEN    = 4;
    localparam int FRAME_CYC    = V_ACT * (H_ACT + HBLANK) + VBLANK;
    localparam int NUM_FRAMES   = 7;
    localparam int WATCHDOG_CYC = NUM_FRAMES * FRAME_CYC + 300;

    typedef struct packed {
        wb_sync_t       sync;
        wb_rgb_t        rgb;
        logic [X_W-1:0] x;
        logic [Y_W-1:0] y;
    } pix_out_t;

    logic           clk;
    logic           rstn;
    wb_sync_t       i_sync;
    wb_rgb_t        i_rgb;
    logic [X_W-1:0] i_x;
    logic [Y_W-1:0] i_y;
    logic           i_en;
    logic           i_update;
    wb_sync_t       o_sync;
    wb_rgb_t        o_rgb;
    logic [X_W-1:0] o_x;
    logic [Y_W-1:0] o_y;
    wb_gains_t      o_gains;

    // Reference model state
    wb_gains_t   exp_gains;
    logic        model_measure;
    logic        model_upd;
    pix_out_t    exp_q[$];
    pix_out_t    exp_out;
    pix_out_t    exp_in;
    logic        sat_phase;
    int          sat_hits;

    white_balance #(
        .H_ACT     (H_ACT     ),
        .V_ACT     (V_ACT     ),
        .DARK_LEVEL(DARK_LEVEL)
    ) UUT (
        .clk     (clk     ),
        .rstn    (rstn    ),
        .i_sync  (i_sync  ),
        .i_rgb   (i_rgb   ),
        .i_x     (i_x     ),
        .i_y     (i_y     ),
        .i_en    (i_en    ),
        .i_update(i_update),
        .o_sync  (o_sync  ),
        .o_rgb   (o_rgb   ),
        .o_x     (o_x     ),
        .o_y     (o_y     ),
        .o_gains (o_gains )
    );

    always #5 clk = ~clk;

    task automatic report_fail(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("tests failed");
        $fatal(1);
    endtask

    function automatic logic [7:0] rand_in(input int lo, input int hi);
        int val;
        val = lo + int'($urandom % (hi - lo + 1));
        return val[7:0];
    endfunction

    // Corrected value is v * gain / 256 clamped to 8 bits
    function automatic logic [7:0] scale_chan(input logic [7:0] v, input wb_gain_t g,
                                              input logic en);
        int p;
        if (!en) begin
            return v;
        end
        p = (int'(v) * int'(g)) >> 8;
        return (p > 255) ? 8'd255 : p[7:0];
    endfunction

    function automatic wb_gain_t gain_of(input int gray, input int avg);
        int q;
        if (avg == 0) begin
            return GAIN_MAX;
        end
        q = (gray * 256) / avg;
        return (q > int'(GAIN_MAX)) ? GAIN_MAX : q[11:0];
    endfunction

    task automatic drive(input logic hs, input logic vs, input logic de, input wb_rgb_t rgb,
                         input int x, input int y, input logic upd);
        @(posedge clk);
        #1;
        i_sync.hsync = hs;
        i_sync.vsync = vs;
        i_sync.de    = de;
        i_rgb        = rgb;
        i_x          = x[X_W-1:0];
        i_y          = y[Y_W-1:0];
        i_update     = upd;
    endtask

    task automatic run_frame(input int lo_r, input int hi_r, input int lo_g, input int hi_g,
                             input int lo_b, input int hi_b, input logic en, input logic upd);
        wb_rgb_t   pix;
        int        sum_r;
        int        sum_g;
        int        sum_b;
        int        cnt;
        int        avg_r;
        int        avg_g;
        int        avg_b;
        int        gray;
        logic      dark;
        wb_gains_t next_gains;
        sum_r      = 0;
        sum_g      = 0;
        sum_b      = 0;
        cnt        = 0;
        next_gains = exp_gains;
        i_en       = en;
        for (int y = 0; y < V_ACT; y++) begin
            for (int x = 0; x < H_ACT; x++) begin
                pix.r = rand_in(lo_r, hi_r);
                pix.g = rand_in(lo_g, hi_g);
                pix.b = rand_in(lo_b, hi_b);
                sum_r += pix.r;
                sum_g += pix.g;
                sum_b += pix.b;
                cnt++;
                drive(1'b0, 1'b0, 1'b1, pix, x, y, upd && x == 3 && y == 2);
            end
            for (int h = 0; h < HBLANK; h++) begin
                drive(h < 2, 1'b0, 1'b0, '0, 0, 0, 1'b0);
            end
        end
        // Controller decision at frame end
        if (upd) begin
            model_upd = 1'b1;
        end
        if (model_measure) begin
            dark = (cnt == 0);
            if (!dark) begin
                avg_r = sum_r / cnt;
                avg_g = sum_g / cnt;
                avg_b = sum_b / cnt;
                gray  = (avg_r + avg_g + avg_b) / 3;
                dark  = avg_r <= DARK_LEVEL && avg_g <= DARK_LEVEL && avg_b <= DARK_LEVEL;
            end
            if (!dark) begin
                next_gains.r  = gain_of(gray, avg_r);
                next_gains.g  = gain_of(gray, avg_g);
                next_gains.b  = gain_of(gray, avg_b);
                model_measure = model_upd;
            end
            model_upd = 1'b0;
        end else if (model_upd) begin
            model_measure = 1'b1;
            model_upd     = 1'b0;
        end
        for (int v = 0; v < VBLANK; v++) begin
            drive(1'b0, v < VSYNC_LEN, 1'b0, '0, 0, 0, 1'b0);
        end
        assert (o_gains == next_gains)
            else report_fail($sformatf("gains %h, expected %h", o_gains, next_gains));
        exp_gains = next_gains;
    endtask

    // Output checker with 2-cycle latency through the queue
    always @(negedge clk) begin
        if (!rstn) begin
            exp_q.delete();
        end else begin
            if (exp_q.size() == 2) begin
                exp_out = exp_q.pop_front();
                assert (o_sync == exp_out.sync && o_x == exp_out.x && o_y == exp_out.y)
                    else report_fail($sformatf("sync/x/y %h %h %h, expected %h %h %h",
                                     o_sync, o_x, o_y, exp_out.sync, exp_out.x, exp_out.y));
                assert (o_rgb == exp_out.rgb)
                    else report_fail($sformatf("rgb %h, expected %h", o_rgb, exp_out.rgb));
                if (sat_phase && o_sync.de && o_rgb.b == 8'hff) begin
                    sat_hits++;
                end
            end
            exp_in.sync  = i_sync;
            exp_in.rgb.r = scale_chan(i_rgb.r, exp_gains.r, i_en);
            exp_in.rgb.g = scale_chan(i_rgb.g, exp_gains.g, i_en);
            exp_in.rgb.b = scale_chan(i_rgb.b, exp_gains.b, i_en);
            exp_in.x     = i_x;
            exp_in.y     = i_y;
            exp_q.push_back(exp_in);
            // Gains must stay put while pixels are active
            if (i_sync.de) begin
                assert (o_gains == exp_gains)
                    else report_fail($sformatf("gains %h mid-frame, expected %h",
                                     o_gains, exp_gains));
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("Timeout: the frame sequence did not finish in %0d clock cycles", WATCHDOG_CYC);
        $display("tests failed");
        $fatal(1);
    end

    initial begin
        void'($urandom(75));
        clk           = 1'b0;
        rstn          = 1'b0;
        // Sync active during reset, the delayed copy must still read zero
        i_sync        = '{hsync: 1'b1, vsync: 1'b0, de: 1'b1};
        i_rgb         = '0;
        i_x           = '0;
        i_y           = '0;
        i_en          = 1'b0;
        i_update      = 1'b0;
        exp_gains     = {GAIN_UNITY, GAIN_UNITY, GAIN_UNITY};
        model_measure = 1'b1;
        model_upd     = 1'b0;
        sat_phase     = 1'b0;
        sat_hits      = 0;
        repeat (2) @(posedge clk);
        #1;
        rstn   = 1'b1;
        i_sync = '0;
        @(negedge clk);
        assert (o_gains == {GAIN_UNITY, GAIN_UNITY, GAIN_UNITY} && o_sync == '0)
            else report_fail($sformatf("after reset gains %h sync %b", o_gains, o_sync));

        // Pass-through frame that is also the first measurement
        run_frame(60, 200, 80, 220, 40, 160, 1'b0, 1'b0);
        // Held
        run_frame(10, 120, 100, 250, 150, 250, 1'b1, 1'b0);
        // Update while held skips this frame
        run_frame(30, 90, 30, 90, 100, 200, 1'b1, 1'b1);
        // Measured with another update pending so measuring continues
        run_frame(120, 240, 50, 150, 70, 190, 1'b1, 1'b1);
        run_frame(0, 4, 0, 4, 0, 4, 1'b1, 1'b0);
        // Weak blue
        run_frame(150, 250, 150, 250, 5, 9, 1'b1, 1'b0);
        assert (o_gains.b == GAIN_MAX)
            else report_fail($sformatf("blue gain %0d did not reach the limit", o_gains.b));
        sat_phase = 1'b1;
        run_frame(100, 255, 100, 255, 100, 255, 1'b1, 1'b0);
        repeat (4) @(posedge clk);

        if (sat_hits > 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            report_fail("no saturated blue output pixel was seen");
        end
    end

endmodule : tb_white_balance

`default_nettype wire

// ==== design/white_balance.sv ====
`timescale 1ns/100ps
`default_nettype none

module white_balance import wb_pkg::*; #(
    parameter int  H_ACT      = 1280,
    parameter int  V_ACT      = 720,
    parameter int  DARK_LEVEL = 4,
    localparam int X_W        = $clog2(H_ACT),
    localparam int Y_W        = $clog2(V_ACT),
    localparam int SUM_W      = $clog2(H_ACT * V_ACT * 255 + 1),
    localparam int CNT_W      = $clog2(H_ACT * V_ACT + 1)
) (
    input  logic           clk,
    input  logic           rstn,
    input  wb_sync_t       i_sync,
    input  wb_rgb_t        i_rgb,
    input  logic [X_W-1:0] i_x,
    input  logic [Y_W-1:0] i_y,
    input  logic           i_en,
    input  logic           i_update,
    output wb_sync_t       o_sync,
    output wb_rgb_t        o_rgb,
    output logic [X_W-1:0] o_x,
    output logic [Y_W-1:0] o_y,
    output wb_gains_t      o_gains
);

    wire             frame_end;
    wire             calc_start;
    wire             calc_done;
    wire             calc_dark;
    wire [SUM_W-1:0] sum_r;
    wire [SUM_W-1:0] sum_g;
    wire [SUM_W-1:0] sum_b;
    wire [CNT_W-1:0] count;

    wb_frame_ctrl u_frame_ctrl (
        .clk         (clk         ),
        .rstn        (rstn        ),
        .i_vsync     (i_sync.vsync),
        .i_update    (i_update    ),
        .i_calc_done (calc_done   ),
        .i_calc_dark (calc_dark   ),
        .o_frame_end (frame_end   ),
        .o_calc_start(calc_start  )
    );

    wb_frame_stats #(
        .H_ACT(H_ACT),
        .V_ACT(V_ACT)
    ) u_frame_stats (
        .clk        (clk      ),
        .rstn       (rstn     ),
        .i_sync     (i_sync   ),
        .i_rgb      (i_rgb    ),
        .i_frame_end(frame_end),
        .o_sum_r    (sum_r    ),
        .o_sum_g    (sum_g    ),
        .o_sum_b    (sum_b    ),
        .o_count    (count    )
    );

    wb_gain_calc #(
        .H_ACT     (H_ACT     ),
        .V_ACT     (V_ACT     ),
        .DARK_LEVEL(DARK_LEVEL)
    ) u_gain_calc (
        .clk    (clk       ),
        .rstn   (rstn      ),
        .i_start(calc_start),
        .i_sum_r(sum_r     ),
        .i_sum_g(sum_g     ),
        .i_sum_b(sum_b     ),
        .i_count(count     ),
        .o_done (calc_done ),
        .o_dark (calc_dark ),
        .o_gains(o_gains   )
    );

    wb_pixel_scale u_pixel_scale (
        .clk    (clk    ),
        .rstn   (rstn   ),
        .i_rgb  (i_rgb  ),
        .i_gains(o_gains),
        .i_en   (i_en   ),
        .o_rgb  (o_rgb  )
    );

    // Sync and position follow the 2-stage colour path
    wb_delay_line #(
        .WIDTH($bits(wb_sync_t) + X_W + Y_W),
        .DEPTH(2                           )
    ) u_delay_line (
        .clk   (clk                 ),
        .rstn  (rstn                ),
        .i_data({i_sync, i_x, i_y}),
        .o_data({o_sync, o_x, o_y})
    );

endmodule : white_balance

`default_nettype wire

// ==== design/wb_delay_line.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_delay_line #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 2
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic [WIDTH-1:0] i_data,
    output logic [WIDTH-1:0] o_data
);

    logic [WIDTH-1:0] stage_q [DEPTH];

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= i_data;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign o_data = stage_q[DEPTH-1];

endmodule : wb_delay_line

`default_nettype wire

// ==== design/wb_pixel_scale.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_pixel_scale import wb_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  wb_rgb_t   i_rgb,
    input  wb_gains_t i_gains,
    input  logic      i_en,
    output wb_rgb_t   o_rgb
);

    logic [19:0] prod_r;
    logic [19:0] prod_g;
    logic [19:0] prod_b;
    wb_rgb_t     orig_q;
    wb_rgb_t     rgb_q;

    // Drop the 8 fraction bits, clamp at 255
    function automatic logic [7:0] sat_shift(input logic [19:0] prod);
        return (prod[19:16] != 4'd0) ? 8'hff : prod[15:8];
    endfunction

    // Stage 1: products next to the original pixel
    always_ff @(posedge clk) begin
        prod_r <= i_rgb.r * i_gains.r;
        prod_g <= i_rgb.g * i_gains.g;
        prod_b <= i_rgb.b * i_gains.b;
        orig_q <= i_rgb;
    end

    // Stage 2: saturate and select
    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            rgb_q <= '0;
        end else if (i_en) begin
            rgb_q.r <= sat_shift(prod_r);
            rgb_q.g <= sat_shift(prod_g);
            rgb_q.b <= sat_shift(prod_b);
        end else begin
            rgb_q <= orig_q;
        end
    end

    assign o_rgb = rgb_q;

endmodule : wb_pixel_scale

`default_nettype wire

// ==== design/wb_gain_calc.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_gain_calc import wb_pkg::*; #(
    parameter int  H_ACT      = 1280,
    parameter int  V_ACT      = 720,
    parameter int  DARK_LEVEL = 4,
    localparam int SUM_W      = $clog2(H_ACT * V_ACT * 255 + 1),
    localparam int CNT_W      = $clog2(H_ACT * V_ACT + 1)
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             i_start,
    input  logic [SUM_W-1:0] i_sum_r,
    input  logic [SUM_W-1:0] i_sum_g,
    input  logic [SUM_W-1:0] i_sum_b,
    input  logic [CNT_W-1:0] i_count,
    output logic             o_done,
    output logic             o_dark,
    output wb_gains_t        o_gains
);

    // Wide enough for the sums and for gray * 256
    localparam int DIV_W = (SUM_W > 16) ? SUM_W : 16;
    localparam int BIT_W = $clog2(DIV_W);

    wb_div_op_e       op;
    logic             load;
    logic [BIT_W-1:0] bit_cnt;
    logic             last_bit;
    logic             done_q;
    logic             dark_q;
    logic             dark_test;
    wb_gains_t        gains_q;

    logic [SUM_W-1:0] sum_r_q;
    logic [SUM_W-1:0] sum_g_q;
    logic [SUM_W-1:0] sum_b_q;
    logic [CNT_W-1:0] count_q;
    logic [7:0]       avg_r;
    logic [7:0]       avg_g;
    logic [7:0]       avg_b;
    logic [7:0]       gray;
    wb_gain_t         gain_r_n;
    wb_gain_t         gain_g_n;
    wb_gain_t         gain_clip;

    logic [DIV_W-1:0] dividend;
    logic [DIV_W-1:0] divisor;
    logic [DIV_W-1:0] div_rem;
    logic [DIV_W-1:0] div_quo;
    logic [DIV_W-1:0] div_dsr;
    logic [DIV_W:0]   div_shift;
    logic [DIV_W:0]   div_trial;
    logic [DIV_W-1:0] rem_nxt;
    logic [DIV_W-1:0] quo_nxt;

    // Operands per opcode
    always_comb begin
        dividend = DIV_W'({gray, 8'd0});
        divisor  = '0;
        case (op)
            DIV_AVG_R: begin
                dividend = DIV_W'(sum_r_q);
                divisor  = DIV_W'(count_q);
            end
            DIV_AVG_G: begin
                dividend = DIV_W'(sum_g_q);
                divisor  = DIV_W'(count_q);
            end
            DIV_AVG_B: begin
                dividend = DIV_W'(sum_b_q);
                divisor  = DIV_W'(count_q);
            end
            DIV_GRAY: begin
                dividend = DIV_W'(avg_r) + DIV_W'(avg_g) + DIV_W'(avg_b);
                divisor  = DIV_W'(3);
            end
            DIV_GAIN_R: divisor = DIV_W'(avg_r);
            DIV_GAIN_G: divisor = DIV_W'(avg_g);
            DIV_GAIN_B: divisor = DIV_W'(avg_b);
            default:    divisor = '0;
        endcase
    end

    // Restoring step, quotient bits shift in from the right
    assign div_shift = {div_rem, div_quo[DIV_W-1]};
    assign div_trial = div_shift - {1'b0, div_dsr};
    assign rem_nxt   = div_trial[DIV_W] ? div_shift[DIV_W-1:0] : div_trial[DIV_W-1:0];
    assign quo_nxt   = {div_quo[DIV_W-2:0], ~div_trial[DIV_W]};
    assign last_bit  = (op != DIV_IDLE) && !load && (bit_cnt == BIT_W'(DIV_W - 1));

    // Zero divisor yields all ones, so a zero average clips to max
    assign gain_clip = (quo_nxt > DIV_W'(GAIN_MAX)) ? GAIN_MAX : quo_nxt[11:0];
    assign dark_test = (count_q == '0) ||
                       (avg_r <= DARK_LEVEL && avg_g <= DARK_LEVEL && avg_b <= DARK_LEVEL);

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            op      <= DIV_IDLE;
            load    <= 1'b0;
            bit_cnt <= '0;
            done_q  <= 1'b0;
            dark_q  <= 1'b0;
            gains_q <= '{GAIN_UNITY, GAIN_UNITY, GAIN_UNITY};
        end else begin
            done_q <= 1'b0;
            if (i_start) begin
                op     <= DIV_AVG_R;
                load   <= 1'b1;
                dark_q <= 1'b0;
            end else if (load) begin
                load    <= 1'b0;
                bit_cnt <= '0;
            end else if (last_bit) begin
                op   <= wb_div_op_e'(op + 3'd1);
                load <= (op != DIV_GAIN_B);
                if (op == DIV_GAIN_B) begin
                    done_q <= 1'b1;
                    dark_q <= dark_test;
                    if (!dark_test) begin
                        gains_q <= '{gain_r_n, gain_g_n, gain_clip};
                    end
                end
            end else if (op != DIV_IDLE) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_start) begin
            sum_r_q <= i_sum_r;
            sum_g_q <= i_sum_g;
            sum_b_q <= i_sum_b;
            count_q <= i_count;
        end
        if (load) begin
            div_rem <= '0;
            div_quo <= dividend;
            div_dsr <= divisor;
        end else if (op != DIV_IDLE) begin
            div_rem <= rem_nxt;
            div_quo <= quo_nxt;
        end
        if (last_bit) begin
            case (op)
                DIV_AVG_R:  avg_r    <= quo_nxt[7:0];
                DIV_AVG_G:  avg_g    <= quo_nxt[7:0];
                DIV_AVG_B:  avg_b    <= quo_nxt[7:0];
                DIV_GRAY:   gray     <= quo_nxt[7:0];
                DIV_GAIN_R: gain_r_n <= gain_clip;
                DIV_GAIN_G: gain_g_n <= gain_clip;
                default:    ;
            endcase
        end
    end

    assign o_done  = done_q;
    assign o_dark  = dark_q;
    assign o_gains = gains_q;

endmodule : wb_gain_calc

`default_nettype wire

// ==== design/wb_frame_stats.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_frame_stats import wb_pkg::*; #(
    parameter int  H_ACT = 1280,
    parameter int  V_ACT = 720,
    localparam int SUM_W = $clog2(H_ACT * V_ACT * 255 + 1),
    localparam int CNT_W = $clog2(H_ACT * V_ACT + 1)
) (
    input  logic             clk,
    input  logic             rstn,
    input  wb_sync_t         i_sync,
    input  wb_rgb_t          i_rgb,
    input  logic             i_frame_end,
    output logic [SUM_W-1:0] o_sum_r,
    output logic [SUM_W-1:0] o_sum_g,
    output logic [SUM_W-1:0] o_sum_b,
    output logic [CNT_W-1:0] o_count
);

    logic [SUM_W-1:0] acc_r;
    logic [SUM_W-1:0] acc_g;
    logic [SUM_W-1:0] acc_b;
    logic [CNT_W-1:0] acc_cnt;

    // Running totals, sized for a full frame of 255s
    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            acc_r   <= '0;
            acc_g   <= '0;
            acc_b   <= '0;
            acc_cnt <= '0;
        end else if (i_frame_end) begin
            acc_r   <= '0;
            acc_g   <= '0;
            acc_b   <= '0;
            acc_cnt <= '0;
        end else if (i_sync.de) begin
            acc_r   <= acc_r + i_rgb.r;
            acc_g   <= acc_g + i_rgb.g;
            acc_b   <= acc_b + i_rgb.b;
            acc_cnt <= acc_cnt + 1'b1;
        end
    end

    // Snapshot of the finished frame
    always_ff @(posedge clk) begin
        if (i_frame_end) begin
            o_sum_r <= acc_r;
            o_sum_g <= acc_g;
            o_sum_b <= acc_b;
            o_count <= acc_cnt;
        end
    end

endmodule : wb_frame_stats

`default_nettype wire

// ==== design/wb_frame_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_frame_ctrl import wb_pkg::*; (
    input  logic clk,
    input  logic rstn,
    input  logic i_vsync,
    input  logic i_update,
    input  logic i_calc_done,
    input  logic i_calc_dark,
    output logic o_frame_end,
    output logic o_calc_start
);

    wb_state_e state;
    logic      vsync_q;
    logic      frame_end_q;
    logic      start_q;
    logic      upd_latch;

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            state       <= WB_MEASURE;
            vsync_q     <= 1'b0;
            frame_end_q <= 1'b0;
            start_q     <= 1'b0;
            upd_latch   <= 1'b0;
        end else begin
            vsync_q     <= i_vsync;
            // Rising vsync, seen one cycle late
            frame_end_q <= i_vsync & ~vsync_q;
            start_q     <= 1'b0;

            if (i_update) begin
                upd_latch <= 1'b1;
            end

            case (state)
                WB_MEASURE: begin
                    if (frame_end_q) begin
                        state   <= WB_CALC;
                        start_q <= 1'b1;
                    end
                end
                // Frame ends in here are dropped
                WB_CALC: begin
                    if (i_calc_done) begin
                        if (i_calc_dark || upd_latch) begin
                            state <= WB_MEASURE;
                        end else begin
                            state <= WB_HOLD;
                        end
                        upd_latch <= i_update;
                    end
                end
                // Frame that ends here is skipped, the next one is measured
                WB_HOLD: begin
                    if (frame_end_q && upd_latch) begin
                        state     <= WB_MEASURE;
                        upd_latch <= i_update;
                    end
                end
                default: begin
                    state <= WB_MEASURE;
                end
            endcase
        end
    end

    assign o_frame_end  = frame_end_q;
    assign o_calc_start = start_q;

endmodule : wb_frame_ctrl

`default_nettype wire

// ==== design/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } wb_sync_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } wb_rgb_t;

    // Unsigned 4.8 fixed point
    typedef logic [11:0] wb_gain_t;

    typedef struct packed {
        wb_gain_t r;
        wb_gain_t g;
        wb_gain_t b;
    } wb_gains_t;

    localparam wb_gain_t GAIN_UNITY = 12'd256;
    localparam wb_gain_t GAIN_MAX   = 12'd4095;

    typedef enum logic [1:0] {
        WB_MEASURE,
        WB_CALC,
        WB_HOLD
    } wb_state_e;

    // Run order follows encoding, GAIN_B wraps back to IDLE
    typedef enum logic [2:0] {
        DIV_IDLE,
        DIV_AVG_R,
        DIV_AVG_G,
        DIV_AVG_B,
        DIV_GRAY,
        DIV_GAIN_R,
        DIV_GAIN_G,
        DIV_GAIN_B
    } wb_div_op_e;

endpackage : wb_pkg

`default_nettype wire
